/* noc_inter_cfg_pkg.sv */
// ====================
// Datapath types and default sizes
// Element, accumulator and requant types
// GELU breakpoint
// ====================

package noc_inter_cfg_pkg;

    // Element and accumulator widths
    localparam int D_W = 8;
    localparam int D_W_ACC = 32;

    typedef logic signed [D_W-1:0] data_t;
    typedef logic signed [D_W_ACC-1:0] acc_t;

    // Requantization multiplier and exponent
    typedef logic signed [31:0] mult_t;
    typedef logic [7:0] shift_t;

    // Hidden size and dot products per run
    localparam int DEFAULT_VEC_LEN = 768;
    localparam int DEFAULT_NUM_VECS = 16;

    localparam int GELU_KNEE = 64;

endpackage

/* noc_inter_ctrl_pkg.sv */
// ====================
// Run FSM state type
// ====================

package noc_inter_ctrl_pkg;

    // IDLE waits for start, RUN streams, FINISH holds done
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        RUN    = 2'd1,
        FINISH = 2'd2
    } ctrl_state_e;

endpackage

/* stream_if.sv */
// ====================
// Valid/ready data stream with last flag
// Source and sink modports
// ====================

`timescale 1ns/1ps

interface stream_if #(
    parameter int DATA_W = noc_inter_cfg_pkg::D_W
);

    logic [DATA_W-1:0] tdata;
    logic              tvalid;
    logic              tready;
    logic              tlast;

    // Producer side
    modport source (output tdata, output tvalid, output tlast, input tready);

    // Consumer side
    modport sink (input tdata, input tvalid, input tlast, output tready);

endinterface

/* dot_product_unit.sv */
// ====================
// Int8 dot product unit
// Pairs A and K elements, accumulates VEC_LEN products
// Frames NUM_VECS results per run, flags tlast mismatches
// ====================

`timescale 1ns/1ps

module dot_product_unit #(
    parameter int VEC_LEN = noc_inter_cfg_pkg::DEFAULT_VEC_LEN,
    parameter int NUM_VECS = noc_inter_cfg_pkg::DEFAULT_NUM_VECS
) (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     run,
    input  noc_inter_cfg_pkg::data_t a_tdata,
    input  logic                     a_tvalid,
    input  logic                     a_tlast,
    output logic                     a_tready,
    input  noc_inter_cfg_pkg::data_t k_tdata,
    input  logic                     k_tvalid,
    input  logic                     k_tlast,
    output logic                     k_tready,
    stream_if.source                 acc_out,
    output logic                     frame_error
);

    localparam int PAIR_W = $clog2(VEC_LEN + 1);
    localparam int VEC_W = $clog2(NUM_VECS + 1);

    logic [PAIR_W-1:0]       pair_cnt;
    logic [VEC_W-1:0]        vec_cnt;
    noc_inter_cfg_pkg::acc_t acc;
    noc_inter_cfg_pkg::acc_t acc_next;
    noc_inter_cfg_pkg::acc_t out_data;
    logic                    out_valid;
    logic                    out_last;
    logic                    run_q;
    logic                    run_rise;
    logic                    finished;
    logic                    take;
    logic                    last_pair;
    logic                    last_vec;

    assign run_rise = run && !run_q;
    assign last_pair = (pair_cnt == PAIR_W'(VEC_LEN - 1));
    assign last_vec = (vec_cnt == VEC_W'(NUM_VECS - 1));

    // Both streams advance together, never while a result is held
    assign take = run_q && !finished && !out_valid && a_tvalid && k_tvalid;
    assign a_tready = take;
    assign k_tready = take;

    assign acc_next = acc + noc_inter_cfg_pkg::acc_t'(a_tdata) *
                            noc_inter_cfg_pkg::acc_t'(k_tdata);

    // ====================
    // Counters and handshake state
    // ====================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            run_q       <= 1'b0;
            pair_cnt    <= '0;
            vec_cnt     <= '0;
            finished    <= 1'b0;
            out_valid   <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            run_q <= run;
            // Input tlast only checked, framing comes from the counts
            frame_error <= take && ((a_tlast != last_pair) || (k_tlast != last_pair));
            if (acc_out.tvalid && acc_out.tready) begin
                out_valid <= 1'b0;
            end
            if (run_rise) begin
                pair_cnt <= '0;
                vec_cnt  <= '0;
                finished <= 1'b0;
            end else if (take) begin
                if (last_pair) begin
                    pair_cnt  <= '0;
                    out_valid <= 1'b1;
                    if (last_vec) begin
                        vec_cnt  <= '0;
                        finished <= 1'b1;
                    end else begin
                        vec_cnt <= vec_cnt + 1'b1;
                    end
                end else begin
                    pair_cnt <= pair_cnt + 1'b1;
                end
            end
        end
    end

    // Accumulator and result register
    always_ff @(posedge clk) begin
        if (run_rise) begin
            acc <= '0;
        end else if (take) begin
            if (last_pair) begin
                acc      <= '0;
                out_data <= acc_next;
                out_last <= last_vec;
            end else begin
                acc <= acc_next;
            end
        end
    end

    assign acc_out.tdata = out_data;
    assign acc_out.tvalid = out_valid;
    assign acc_out.tlast = out_last;

    // Pairs only flow inside a run granted by the control FSM
    a_no_take_idle: assert property (@(posedge clk) disable iff (!rstn)
        !run |-> !(a_tvalid && a_tready) && !(k_tvalid && k_tready));

endmodule

/* requant_stage.sv */
// ====================
// Requantization stage
// Multiply, arithmetic right shift, int8 clip
// One output register
// ====================

`timescale 1ns/1ps

module requant_stage (
    input  logic                      clk,
    input  logic                      rstn,
    stream_if.sink                    in_s,
    stream_if.source                  out_s,
    input  noc_inter_cfg_pkg::mult_t  m,
    input  noc_inter_cfg_pkg::shift_t e
);

    localparam logic signed [63:0] Q_MAX = (64'sd1 <<< (noc_inter_cfg_pkg::D_W - 1)) - 64'sd1;
    localparam logic signed [63:0] Q_MIN = -(64'sd1 <<< (noc_inter_cfg_pkg::D_W - 1));

    noc_inter_cfg_pkg::acc_t  in_val;
    logic signed [63:0]       product;
    logic signed [63:0]       shifted;
    noc_inter_cfg_pkg::data_t clipped;
    noc_inter_cfg_pkg::data_t out_data;
    logic                     out_valid;
    logic                     out_last;
    logic                     in_take;

    assign in_val = noc_inter_cfg_pkg::acc_t'(in_s.tdata);
    assign product = 64'(in_val) * 64'(m);
    assign shifted = product >>> e;

    // Saturate to the int8 range
    always_comb begin
        if (shifted > Q_MAX) begin
            clipped = noc_inter_cfg_pkg::data_t'(Q_MAX);
        end else if (shifted < Q_MIN) begin
            clipped = noc_inter_cfg_pkg::data_t'(Q_MIN);
        end else begin
            clipped = noc_inter_cfg_pkg::data_t'(shifted);
        end
    end

    // Accept when empty or when the held item leaves this cycle
    assign in_s.tready = !out_valid || out_s.tready;
    assign in_take = in_s.tvalid && in_s.tready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (in_take) begin
            out_valid <= 1'b1;
        end else if (out_s.tready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_take) begin
            out_data <= clipped;
            out_last <= in_s.tlast;
        end
    end

    assign out_s.tdata = out_data;
    assign out_s.tvalid = out_valid;
    assign out_s.tlast = out_last;

    a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
        out_s.tvalid && !out_s.tready |=> out_s.tvalid && $stable(out_s.tdata)
                                          && $stable(out_s.tlast));

endmodule

/* gelu_approx.sv */
// ====================
// GELU approximation on int8 values
// Piecewise quadratic around +/- GELU_KNEE
// One output register, int32 result
// ====================

`timescale 1ns/1ps

module gelu_approx (
    input  logic     clk,
    input  logic     rstn,
    stream_if.sink   in_s,
    stream_if.source out_s
);

    // Scale of the quadratic segment
    localparam int GELU_SHIFT = 7;

    noc_inter_cfg_pkg::data_t x;
    noc_inter_cfg_pkg::acc_t  x_ext;
    noc_inter_cfg_pkg::acc_t  gelu_val;
    noc_inter_cfg_pkg::acc_t  out_data;
    logic                     out_valid;
    logic                     out_last;
    logic                     in_take;

    assign x = noc_inter_cfg_pkg::data_t'(in_s.tdata);
    assign x_ext = noc_inter_cfg_pkg::acc_t'(x);

    always_comb begin
        if (x_ext >= noc_inter_cfg_pkg::GELU_KNEE) begin
            gelu_val = x_ext;
        end else if (x_ext <= -noc_inter_cfg_pkg::GELU_KNEE) begin
            gelu_val = '0;
        end else begin
            // x * (x + knee) / 128, rounded toward minus infinity
            gelu_val = (x_ext * (x_ext + noc_inter_cfg_pkg::GELU_KNEE)) >>> GELU_SHIFT;
        end
    end

    assign in_s.tready = !out_valid || out_s.tready;
    assign in_take = in_s.tvalid && in_s.tready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else if (in_take) begin
            out_valid <= 1'b1;
        end else if (out_s.tready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_take) begin
            out_data <= gelu_val;
            out_last <= in_s.tlast;
        end
    end

    assign out_s.tdata = out_data;
    assign out_s.tvalid = out_valid;
    assign out_s.tlast = out_last;

endmodule

/* inter_control.sv */
// ====================
// Run control FSM
// Start, done and error levels
// Done on the final G transfer
// ====================

`timescale 1ns/1ps

module inter_control (
    input  logic clk,
    input  logic rstn,
    input  logic start,
    output logic run,
    input  logic frame_error,
    input  logic g_tvalid,
    input  logic g_tready,
    input  logic g_tlast,
    output logic done,
    output logic error
);

    noc_inter_ctrl_pkg::ctrl_state_e state;
    logic                            g_final;

    assign g_final = g_tvalid && g_tready && g_tlast;
    assign run = (state == noc_inter_ctrl_pkg::RUN);

    // ====================
    // State and status flags
    // ====================
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= noc_inter_ctrl_pkg::IDLE;
            done  <= 1'b0;
            error <= 1'b0;
        end else begin
            case (state)
                noc_inter_ctrl_pkg::IDLE: begin
                    if (start) begin
                        state <= noc_inter_ctrl_pkg::RUN;
                        done  <= 1'b0;
                        error <= 1'b0;
                    end
                end
                noc_inter_ctrl_pkg::RUN: begin
                    // Sticky until the next start
                    if (frame_error) begin
                        error <= 1'b1;
                    end
                    if (g_final) begin
                        state <= noc_inter_ctrl_pkg::FINISH;
                        done  <= 1'b1;
                    end
                end
                noc_inter_ctrl_pkg::FINISH: begin
                    if (start) begin
                        state <= noc_inter_ctrl_pkg::RUN;
                        done  <= 1'b0;
                        error <= 1'b0;
                    end
                end
                default: begin
                    state <= noc_inter_ctrl_pkg::IDLE;
                end
            endcase
        end
    end

    a_no_done_in_run: assert property (@(posedge clk) disable iff (!rstn)
        state == noc_inter_ctrl_pkg::RUN |-> !done);

endmodule

/* noc_inter_top.sv */
// ====================
// Intermediate stage top level
// A~ x K'^T -> requant -> GELU -> requant -> G~
// Plain stream ports, internal stream interfaces
// ====================

`timescale 1ns/1ps

module noc_inter_top #(
    parameter int VEC_LEN = noc_inter_cfg_pkg::DEFAULT_VEC_LEN,
    parameter int NUM_VECS = noc_inter_cfg_pkg::DEFAULT_NUM_VECS
) (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      start,
    output logic                      done,
    output logic                      error,
    input  noc_inter_cfg_pkg::data_t  a_tdata,
    input  logic                      a_tvalid,
    input  logic                      a_tlast,
    output logic                      a_tready,
    input  noc_inter_cfg_pkg::data_t  k_tdata,
    input  logic                      k_tvalid,
    input  logic                      k_tlast,
    output logic                      k_tready,
    output noc_inter_cfg_pkg::data_t  g_tdata,
    output logic                      g_tvalid,
    output logic                      g_tlast,
    input  logic                      g_tready,
    input  noc_inter_cfg_pkg::mult_t  requant_m_mult,
    input  noc_inter_cfg_pkg::shift_t requant_e_mult,
    input  noc_inter_cfg_pkg::mult_t  requant_m_g,
    input  noc_inter_cfg_pkg::shift_t requant_e_g
);

    logic run;
    logic frame_error;

    stream_if #(.DATA_W(noc_inter_cfg_pkg::D_W_ACC)) acc_s ();
    stream_if #(.DATA_W(noc_inter_cfg_pkg::D_W)) q_s ();
    stream_if #(.DATA_W(noc_inter_cfg_pkg::D_W_ACC)) gelu_s ();
    // Output of the last stage, mapped onto the g ports
    stream_if #(.DATA_W(noc_inter_cfg_pkg::D_W)) g_s ();

    inter_control u_control (
        .clk         (clk),
        .rstn        (rstn),
        .start       (start),
        .run         (run),
        .frame_error (frame_error),
        .g_tvalid    (g_tvalid),
        .g_tready    (g_tready),
        .g_tlast     (g_tlast),
        .done        (done),
        .error       (error)
    );

    dot_product_unit #(
        .VEC_LEN  (VEC_LEN),
        .NUM_VECS (NUM_VECS)
    ) u_dot (
        .clk         (clk),
        .rstn        (rstn),
        .run         (run),
        .a_tdata     (a_tdata),
        .a_tvalid    (a_tvalid),
        .a_tlast     (a_tlast),
        .a_tready    (a_tready),
        .k_tdata     (k_tdata),
        .k_tvalid    (k_tvalid),
        .k_tlast     (k_tlast),
        .k_tready    (k_tready),
        .acc_out     (acc_s.source),
        .frame_error (frame_error)
    );

    // ====================
    // Requant, GELU, requant
    // ====================
    requant_stage u_requant_mm (
        .clk   (clk),
        .rstn  (rstn),
        .in_s  (acc_s.sink),
        .out_s (q_s.source),
        .m     (requant_m_mult),
        .e     (requant_e_mult)
    );

    gelu_approx u_gelu (
        .clk   (clk),
        .rstn  (rstn),
        .in_s  (q_s.sink),
        .out_s (gelu_s.source)
    );

    requant_stage u_requant_gelu (
        .clk   (clk),
        .rstn  (rstn),
        .in_s  (gelu_s.sink),
        .out_s (g_s.source),
        .m     (requant_m_g),
        .e     (requant_e_g)
    );

    assign g_tdata = g_s.tdata;
    assign g_tvalid = g_s.tvalid;
    assign g_tlast = g_s.tlast;
    assign g_s.tready = g_tready;

endmodule

/* tb_noc_inter.sv */
// ====================
// Testbench for the intermediate stage
// LCG stimulus with gaps and back-pressure
// Reference model of requant, GELU, requant
// ====================

`timescale 1ns/1ps

module tb_noc_inter;

    localparam int VEC_LEN = 8;
    localparam int NUM_VECS = 6;
    localparam int TOTAL = VEC_LEN * NUM_VECS;
    localparam int RUN_LIMIT = 2000;

    logic                      clk;
    logic                      rstn;
    logic                      start;
    logic                      done;
    logic                      error;
    noc_inter_cfg_pkg::data_t  a_tdata;
    logic                      a_tvalid;
    logic                      a_tlast;
    logic                      a_tready;
    noc_inter_cfg_pkg::data_t  k_tdata;
    logic                      k_tvalid;
    logic                      k_tlast;
    logic                      k_tready;
    noc_inter_cfg_pkg::data_t  g_tdata;
    logic                      g_tvalid;
    logic                      g_tlast;
    logic                      g_tready;
    noc_inter_cfg_pkg::mult_t  requant_m_mult;
    noc_inter_cfg_pkg::shift_t requant_e_mult;
    noc_inter_cfg_pkg::mult_t  requant_m_g;
    noc_inter_cfg_pkg::shift_t requant_e_g;

    noc_inter_cfg_pkg::data_t a_mem [TOTAL];
    noc_inter_cfg_pkg::data_t k_mem [TOTAL];
    logic [31:0]              rng_state;
    int                       errors;
    int                       checks;
    bit                       timed_out;

    noc_inter_top #(
        .VEC_LEN  (VEC_LEN),
        .NUM_VECS (NUM_VECS)
    ) uut (
        .clk            (clk),
        .rstn           (rstn),
        .start          (start),
        .done           (done),
        .error          (error),
        .a_tdata        (a_tdata),
        .a_tvalid       (a_tvalid),
        .a_tlast        (a_tlast),
        .a_tready       (a_tready),
        .k_tdata        (k_tdata),
        .k_tvalid       (k_tvalid),
        .k_tlast        (k_tlast),
        .k_tready       (k_tready),
        .g_tdata        (g_tdata),
        .g_tvalid       (g_tvalid),
        .g_tlast        (g_tlast),
        .g_tready       (g_tready),
        .requant_m_mult (requant_m_mult),
        .requant_e_mult (requant_e_mult),
        .requant_m_g    (requant_m_g),
        .requant_e_g    (requant_e_g)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    function automatic longint clip_int8(input longint x);
        if (x > 127) begin
            return 127;
        end else if (x < -128) begin
            return -128;
        end
        return x;
    endfunction

    // ====================
    // Reference model
    // ====================
    function automatic longint model_output(input int v);
        longint acc;
        longint q;
        longint gel;
        int     i;
        acc = 0;
        for (i = 0; i < VEC_LEN; i++) begin
            acc += longint'(a_mem[v * VEC_LEN + i]) * longint'(k_mem[v * VEC_LEN + i]);
        end
        q = clip_int8((acc * longint'(requant_m_mult)) >>> requant_e_mult);
        if (q >= 64) begin
            gel = q;
        end else if (q <= -64) begin
            gel = 0;
        end else begin
            // Floor of q * (q + 64) / 128
            gel = (q * (q + 64)) >>> 7;
        end
        return clip_int8((gel * longint'(requant_m_g)) >>> requant_e_g);
    endfunction

    task automatic check_value(input string name, input longint expected, input longint actual);
        checks++;
        assert (expected == actual) else begin
            $display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic fill_vectors();
        logic [31:0] r;
        for (int i = 0; i < TOTAL; i++) begin
            r = next_rand();
            a_mem[i] = r[31:24];
            k_mem[i] = r[23:16];
        end
    endtask

    // One full run from start to done
    task automatic do_run(input string name, input bit gaps, input bit bp,
                          input bit early_tlast,
                          input noc_inter_cfg_pkg::mult_t m1, input noc_inter_cfg_pkg::shift_t e1,
                          input noc_inter_cfg_pkg::mult_t m2, input noc_inter_cfg_pkg::shift_t e2);
        int          pair_idx;
        int          k_idx;
        int          out_idx;
        int          cycles;
        int          pos;
        bit          a_fire;
        bit          k_fire;
        bit          g_fire;
        bit          over;
        logic [31:0] r;
        if (timed_out) begin
            return;
        end
        fill_vectors();
        pair_idx = 0;
        k_idx = 0;
        out_idx = 0;
        cycles = 0;
        a_fire = 0;
        k_fire = 0;
        over = 0;
        @(posedge clk);
        requant_m_mult <= m1;
        requant_e_mult <= e1;
        requant_m_g <= m2;
        requant_e_g <= e2;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_value({name, " done at start"}, 0, done);
        check_value({name, " error at start"}, 0, error);
        while (!over) begin
            @(posedge clk);
            if (a_fire) begin
                pair_idx++;
            end
            if (k_fire) begin
                k_idx++;
            end
            r = next_rand();
            if (pair_idx < TOTAL) begin
                pos = pair_idx % VEC_LEN;
                a_tdata <= a_mem[pair_idx];
                a_tvalid <= !gaps || (r[31:30] != 2'b00);
                // Second vector ends one pair too soon on A
                if (early_tlast && (pair_idx / VEC_LEN == 1)) begin
                    a_tlast <= (pos == VEC_LEN - 2);
                end else begin
                    a_tlast <= (pos == VEC_LEN - 1);
                end
            end else begin
                a_tvalid <= 1'b0;
                a_tlast <= 1'b0;
            end
            // K stream follows its own handshake
            if (k_idx < TOTAL) begin
                k_tdata <= k_mem[k_idx];
                k_tvalid <= !gaps || (r[29:28] != 2'b00);
                k_tlast <= (k_idx % VEC_LEN == VEC_LEN - 1);
            end else begin
                k_tvalid <= 1'b0;
                k_tlast <= 1'b0;
            end
            g_tready <= !bp || r[27];
            @(negedge clk);
            if (out_idx == NUM_VECS) begin
                check_value({name, " done after last"}, 1, done);
                check_value({name, " g_tvalid after last"}, 0, g_tvalid);
                over = 1;
            end else begin
                a_fire = a_tvalid && a_tready;
                k_fire = k_tvalid && k_tready;
                g_fire = g_tvalid && g_tready;
                if (g_fire) begin
                    check_value($sformatf("%s g_tdata[%0d]", name, out_idx),
                                model_output(out_idx), g_tdata);
                    check_value($sformatf("%s g_tlast[%0d]", name, out_idx),
                                out_idx == NUM_VECS - 1, g_tlast);
                    check_value({name, " done before last"}, 0, done);
                    out_idx++;
                end
                cycles++;
                if (cycles > RUN_LIMIT) begin
                    $display("Timeout: %s got only %0d of %0d outputs", name, out_idx, NUM_VECS);
                    errors++;
                    timed_out = 1;
                    over = 1;
                end
            end
        end
        if (!timed_out) begin
            check_value({name, " A pairs consumed"}, TOTAL, pair_idx);
            check_value({name, " K pairs consumed"}, TOTAL, k_idx);
            check_value({name, " error flag"}, early_tlast, error);
        end
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        start = 1'b0;
        a_tdata = '0;
        a_tvalid = 1'b0;
        a_tlast = 1'b0;
        k_tdata = '0;
        k_tvalid = 1'b0;
        k_tlast = 1'b0;
        g_tready = 1'b0;
        requant_m_mult = 32'sd1;
        requant_e_mult = 8'd9;
        requant_m_g = 32'sd1;
        requant_e_g = 8'd0;
        rng_state = 32'd84;
        errors = 0;
        checks = 0;
        timed_out = 0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        check_value("reset done", 0, done);
        check_value("reset error", 0, error);
        check_value("reset a_tready", 0, a_tready);
        check_value("reset k_tready", 0, k_tready);
        check_value("reset g_tvalid", 0, g_tvalid);
        do_run("plain run", 0, 0, 0, 32'sd1, 8'd9, 32'sd1, 8'd0);
        do_run("stall run", 1, 1, 0, 32'sd1, 8'd9, 32'sd1, 8'd0);
        // Huge multiplier drives the first requant into the clip
        do_run("saturation run", 1, 0, 0, 32'sd1048576, 8'd0, 32'sd1, 8'd0);
        do_run("frame error run", 0, 1, 1, 32'sd1, 8'd9, 32'sd1, 8'd0);
        do_run("scaled gelu run", 1, 1, 0, 32'sd1, 8'd9, 32'sd3, 8'd1);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* project.f */
noc_inter_cfg_pkg.sv
noc_inter_ctrl_pkg.sv
stream_if.sv
dot_product_unit.sv
requant_stage.sv
gelu_approx.sv
inter_control.sv
noc_inter_top.sv
tb_noc_inter.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the intermediate stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_noc_inter -f project.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0
